//--- verilog.f
+incdir+verilog
verilog/emu_pkg.sv
verilog/emu_reg_if.sv
verilog/emu_csr_slave.sv
verilog/emu_step_counter.sv
verilog/emu_run_ctrl.sv
verilog/emu_controller.sv
tb/tb_emu_controller.sv

//--- Bender.yml
package:
  name: emu_controller

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/emu_pkg.sv
      - verilog/emu_reg_if.sv
      - verilog/emu_csr_slave.sv
      - verilog/emu_step_counter.sv
      - verilog/emu_run_ctrl.sv
      - verilog/emu_controller.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_emu_controller.sv

//--- tb/tb_emu_controller.sv
`timescale 1ns/1ps
`include "emu_defines.svh"

module tb_emu_controller;
    import emu_pkg::*;

    localparam int TIMEOUT = 200;

    logic       clk;
    logic       rst;
    logic       awvalid;
    logic       awready;
    csr_addr_t  awaddr;
    logic       wvalid;
    logic       wready;
    csr_data_t  wdata;
    csr_strb_t  wstrb;
    logic       bvalid;
    logic       bready;
    axi_resp_t  bresp;
    logic       arvalid;
    logic       arready;
    csr_addr_t  araddr;
    logic       rvalid;
    logic       rready;
    axi_resp_t  rresp;
    csr_data_t  rdata;
    trig_vec_t  dut_trig;
    logic       dut_clk_en;
    logic       dut_rst;

    logic [31:0] lfsr_state = 32'hbdf0_d76c;

    // Register model
    logic       m_pause;
    logic       m_dut_rst;
    logic       m_step_trig;
    trig_vec_t  m_trig;
    cycle_t     m_cycle;
    csr_data_t  m_step;

    emu_controller DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic csr_data_t expected_read(input csr_addr_t addr);
        csr_data_t stat;
        stat = '0;
        stat[`EMU_STAT_PAUSE]     = m_pause;
        stat[`EMU_STAT_DUT_RST]   = m_dut_rst;
        stat[`EMU_STAT_STEP_TRIG] = m_step_trig;
        case (addr)
            `EMU_STAT:      return stat;
            `EMU_TRIG_STAT: return m_trig;
            `EMU_CYCLE_LO:  return m_cycle[31:0];
            `EMU_CYCLE_HI:  return m_cycle[63:32];
            `EMU_STEP:      return m_step;
            default:        return '0;
        endcase
    endfunction

    task automatic model_write(input csr_addr_t addr, input csr_data_t data);
        case (addr)
            `EMU_STAT: begin
                m_pause   = data[`EMU_STAT_PAUSE];
                m_dut_rst = data[`EMU_STAT_DUT_RST];
            end
            `EMU_CYCLE_LO: if (m_pause) m_cycle[31:0] = data;
            `EMU_CYCLE_HI: if (m_pause) m_cycle[63:32] = data;
            `EMU_STEP:     m_step = data;
            default: ;
        endcase
    endtask

    task automatic fail_stop();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input csr_data_t got, input csr_data_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_resp(input axi_resp_t got, input axi_resp_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic count_wait(inout int n, input string what);
        n++;
        if (n > TIMEOUT) begin
            $display("Timeout while waiting for %s", what);
            fail_stop();
        end
    endtask

    task automatic axil_write(input csr_addr_t addr, input csr_data_t data,
                              input csr_strb_t strb, output axi_resp_t resp);
        int        n;
        logic      aw_fire;
        logic      w_fire;
        axi_resp_t first_resp;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (awvalid || wvalid) begin
            @(negedge clk);
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            @(posedge clk);
            #2;
            if (aw_fire) awvalid = 1'b0;
            if (w_fire) wvalid = 1'b0;
            count_wait(n, "awready and wready");
        end
        n = 0;
        @(negedge clk);
        while (!bvalid) begin
            count_wait(n, "bvalid");
            @(negedge clk);
        end
        first_resp = bresp;
        // Hold off bready for a random number of cycles
        repeat (lfsr_bits(3)) begin
            @(negedge clk);
            check_level(bvalid, 1'b1, "bvalid under back-pressure");
            check_resp(bresp, first_resp, "bresp under back-pressure");
        end
        @(posedge clk);
        #2;
        bready = 1'b1;
        @(negedge clk);
        check_level(bvalid, 1'b1, "bvalid at handshake");
        check_resp(bresp, first_resp, "bresp at handshake");
        resp = bresp;
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axil_read(input csr_addr_t addr, output csr_data_t data,
                             output axi_resp_t resp);
        int        n;
        logic      fire;
        csr_data_t first_data;
        axi_resp_t first_resp;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            fire = arready;
            @(posedge clk);
            #2;
            count_wait(n, "arready");
        end while (!fire);
        arvalid = 1'b0;
        n = 0;
        @(negedge clk);
        while (!rvalid) begin
            count_wait(n, "rvalid");
            @(negedge clk);
        end
        first_data = rdata;
        first_resp = rresp;
        repeat (lfsr_bits(3)) begin
            @(negedge clk);
            check_level(rvalid, 1'b1, "rvalid under back-pressure");
            check_data(rdata, first_data, "rdata under back-pressure");
            check_resp(rresp, first_resp, "rresp under back-pressure");
        end
        @(posedge clk);
        #2;
        rready = 1'b1;
        @(negedge clk);
        check_level(rvalid, 1'b1, "rvalid at handshake");
        check_data(rdata, first_data, "rdata at handshake");
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic write_reg(input csr_addr_t addr, input csr_data_t data);
        axi_resp_t resp;
        axil_write(addr, data, 4'hF, resp);
        check_resp(resp, `AXI_RESP_OKAY, "bresp of full write");
        model_write(addr, data);
    endtask

    task automatic read_check(input csr_addr_t addr);
        csr_data_t data;
        axi_resp_t resp;
        axil_read(addr, data, resp);
        check_resp(resp, `AXI_RESP_OKAY, "rresp");
        check_data(data, expected_read(addr), $sformatf("register 0x%03h", addr));
    endtask

    task automatic read_all();
        read_check(`EMU_STAT);
        read_check(`EMU_TRIG_STAT);
        read_check(`EMU_CYCLE_LO);
        read_check(`EMU_CYCLE_HI);
        read_check(`EMU_STEP);
    endtask

    // Poll the status register until pause reads back as set
    task automatic wait_paused();
        int        n;
        csr_data_t data;
        axi_resp_t resp;
        n = 0;
        do begin
            axil_read(`EMU_STAT, data, resp);
            count_wait(n, "pause in the status register");
        end while (!data[`EMU_STAT_PAUSE]);
    endtask

    initial begin
        csr_data_t data;
        axi_resp_t resp;
        csr_strb_t strb;
        int        steps;
        trig_vec_t pattern;

        rst      = 1'b1;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b0;
        dut_trig = '0;
        m_pause     = 1'b1;
        m_dut_rst   = 1'b1;
        m_step_trig = 1'b0;
        m_trig      = '0;
        m_cycle     = '0;
        m_step      = '0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        // Reset state
        @(negedge clk);
        check_level(dut_rst, 1'b1, "dut_rst after reset");
        check_level(dut_clk_en, 1'b0, "dut_clk_en after reset");
        check_level(awready, 1'b1, "awready after reset");
        check_level(wready, 1'b1, "wready after reset");
        check_level(arready, 1'b1, "arready after reset");
        check_level(bvalid, 1'b0, "bvalid after reset");
        check_level(rvalid, 1'b0, "rvalid after reset");
        @(posedge clk);
        #2;
        axil_read(`EMU_STAT, data, resp);
        check_data(data, 32'h3, "status after reset");
        read_all();
        read_check(12'h014);
        read_check(12'hFFC);

        // Cycle halves while paused and a partial strobe write
        write_reg(`EMU_CYCLE_LO, lfsr_bits(32));
        write_reg(`EMU_CYCLE_HI, lfsr_bits(32));
        read_all();
        strb = csr_strb_t'(lfsr_bits(4)) & 4'b1110;
        axil_write(`EMU_CYCLE_LO, lfsr_bits(32), strb, resp);
        check_resp(resp, `AXI_RESP_SLVERR, "bresp of partial write");
        read_check(`EMU_CYCLE_LO);

        // Step run of 1 to 64 cycles
        steps = lfsr_bits(6) + 1;
        write_reg(`EMU_STEP, steps);
        write_reg(`EMU_STAT, 32'h2);
        wait_paused();
        m_pause     = 1'b1;
        m_step_trig = 1'b1;
        m_cycle     = m_cycle + cycle_t'(steps);
        m_step      = '0;
        read_all();
        check_level(dut_clk_en, 1'b0, "dut_clk_en after step run");

        // Trigger from the emulated design
        do begin
            pattern = lfsr_bits(32);
        end while (pattern == '0);
        write_reg(`EMU_STAT, 32'h2);
        check_level(dut_clk_en, 1'b1, "dut_clk_en while running");
        dut_trig = pattern;
        @(posedge clk);
        #2;
        dut_trig = '0;
        wait_paused();
        m_pause     = 1'b1;
        m_step_trig = 1'b0;
        m_trig      = pattern;
        read_check(`EMU_TRIG_STAT);
        read_check(`EMU_STAT);
        write_reg(`EMU_STAT, 32'h1);
        axil_read(`EMU_STAT, data, resp);
        check_data(data, 32'h1, "status after clearing DUT reset");
        check_level(dut_rst, 1'b0, "dut_rst after clearing");

        // More traffic under random back-pressure
        repeat (6) begin
            write_reg(`EMU_CYCLE_LO, lfsr_bits(32));
            write_reg(`EMU_CYCLE_HI, lfsr_bits(32));
            write_reg(`EMU_STEP, lfsr_bits(32));
            axil_write(`EMU_STEP, lfsr_bits(32), csr_strb_t'(lfsr_bits(4)) & 4'b0111, resp);
            check_resp(resp, `AXI_RESP_SLVERR, "bresp of partial write");
            read_all();
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- verilog/emu_controller.sv
`timescale 1ns/1ps

module emu_controller (
    input  logic                clk,
    input  logic                rst,

    input  logic                awvalid,
    output logic                awready,
    input  emu_pkg::csr_addr_t  awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  emu_pkg::csr_data_t  wdata,
    input  emu_pkg::csr_strb_t  wstrb,
    output logic                bvalid,
    input  logic                bready,
    output emu_pkg::axi_resp_t  bresp,
    input  logic                arvalid,
    output logic                arready,
    input  emu_pkg::csr_addr_t  araddr,
    output logic                rvalid,
    input  logic                rready,
    output emu_pkg::axi_resp_t  rresp,
    output emu_pkg::csr_data_t  rdata,

    input  emu_pkg::trig_vec_t  dut_trig,
    output logic                dut_clk_en,
    output logic                dut_rst
);

    emu_reg_if reg_bus ();

    // AXI4-Lite side
    emu_csr_slave u_slave (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rresp   (rresp),
        .rdata   (rdata),
        .regs    (reg_bus.bus)
    );

    // Registers and emulated design control
    emu_run_ctrl u_run_ctrl (
        .clk        (clk),
        .rst        (rst),
        .regs       (reg_bus.regs),
        .dut_trig   (dut_trig),
        .dut_clk_en (dut_clk_en),
        .dut_rst    (dut_rst)
    );

endmodule

//--- verilog/emu_run_ctrl.sv
`timescale 1ns/1ps
`include "emu_defines.svh"

module emu_run_ctrl (
    input  logic                clk,
    input  logic                rst,
    emu_reg_if.regs             regs,
    input  emu_pkg::trig_vec_t  dut_trig,
    output logic                dut_clk_en,
    output logic                dut_rst
);
    import emu_pkg::*;

    logic       pause;
    logic       dut_reset;
    logic       step_trig;
    trig_vec_t  trig_stat;
    cycle_t     cycle;
    csr_data_t  step_count;
    logic       step_expire;
    logic       trigger;
    csr_data_t  stat_word;

    logic       wr_stat;
    logic       wr_cycle_lo;
    logic       wr_cycle_hi;
    logic       wr_step;

    // Write address decode
    assign wr_stat     = regs.wr_en && regs.wr_addr == `EMU_STAT;
    assign wr_cycle_lo = regs.wr_en && regs.wr_addr == `EMU_CYCLE_LO;
    assign wr_cycle_hi = regs.wr_en && regs.wr_addr == `EMU_CYCLE_HI;
    assign wr_step     = regs.wr_en && regs.wr_addr == `EMU_STEP;

    assign trigger = step_expire || (|dut_trig);

    // Trigger wins over a status write in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pause     <= 1'b1;
            dut_reset <= 1'b1;
            step_trig <= 1'b0;
            trig_stat <= '0;
        end else if (trigger) begin
            pause     <= 1'b1;
            step_trig <= step_expire;
            trig_stat <= dut_trig;
        end else if (wr_stat) begin
            pause     <= regs.wr_data[`EMU_STAT_PAUSE];
            dut_reset <= regs.wr_data[`EMU_STAT_DUT_RST];
        end
    end

    // Emulated cycles are host writable only while paused
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (!pause) begin
            cycle <= cycle + 1'b1;
        end else begin
            if (wr_cycle_lo) begin
                cycle[`EMU_CSR_DATA_W-1:0] <= regs.wr_data;
            end
            if (wr_cycle_hi) begin
                cycle[`EMU_CYCLE_W-1:`EMU_CSR_DATA_W] <= regs.wr_data;
            end
        end
    end

    emu_step_counter u_step (
        .clk        (clk),
        .rst        (rst),
        .load       (wr_step),
        .load_value (regs.wr_data),
        .pause      (pause),
        .count      (step_count),
        .expire     (step_expire)
    );

    always_comb begin
        stat_word                      = '0;
        stat_word[`EMU_STAT_PAUSE]     = pause;
        stat_word[`EMU_STAT_DUT_RST]   = dut_reset;
        stat_word[`EMU_STAT_STEP_TRIG] = step_trig;
    end

    // Read lookup
    always_comb begin
        case (regs.rd_addr)
            `EMU_STAT:      regs.rd_data = stat_word;
            `EMU_TRIG_STAT: regs.rd_data = trig_stat;
            `EMU_CYCLE_LO:  regs.rd_data = cycle[`EMU_CSR_DATA_W-1:0];
            `EMU_CYCLE_HI:  regs.rd_data = cycle[`EMU_CYCLE_W-1:`EMU_CSR_DATA_W];
            `EMU_STEP:      regs.rd_data = step_count;
            default:        regs.rd_data = '0;
        endcase
    end

    assign dut_clk_en = !pause;
    assign dut_rst    = dut_reset;

    // Step expiry or a DUT trigger always stops the clock next cycle
    a_trigger_pauses: assert property (@(posedge clk) disable iff (rst)
        trigger |=> pause && !dut_clk_en);

endmodule

//--- verilog/emu_step_counter.sv
`timescale 1ns/1ps

module emu_step_counter (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  emu_pkg::csr_data_t  load_value,
    input  logic                pause,
    output emu_pkg::csr_data_t  count,
    output logic                expire
);
    import emu_pkg::*;

    csr_data_t count_q;
    csr_data_t count_next;

    // Count down only while the emulated design runs
    always_comb begin
        if (pause) begin
            count_next = count_q;
        end else if (count_q != '0) begin
            count_next = count_q - 1'b1;
        end else begin
            count_next = '0;
        end
    end

    // Last unpaused step reaches zero
    assign expire = count_q != '0 && count_next == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (load) begin
            count_q <= load_value;
        end else begin
            count_q <= count_next;
        end
    end

    assign count = count_q;

    a_no_expire_paused: assert property (@(posedge clk) disable iff (rst)
        pause |-> !expire);

endmodule

//--- verilog/emu_csr_slave.sv
`timescale 1ns/1ps
`include "emu_defines.svh"

module emu_csr_slave (
    input  logic                clk,
    input  logic                rst,
    input  logic                awvalid,
    output logic                awready,
    input  emu_pkg::csr_addr_t  awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  emu_pkg::csr_data_t  wdata,
    input  emu_pkg::csr_strb_t  wstrb,
    output logic                bvalid,
    input  logic                bready,
    output emu_pkg::axi_resp_t  bresp,
    input  logic                arvalid,
    output logic                arready,
    input  emu_pkg::csr_addr_t  araddr,
    output logic                rvalid,
    input  logic                rready,
    output emu_pkg::axi_resp_t  rresp,
    output emu_pkg::csr_data_t  rdata,
    emu_reg_if.bus              regs
);
    import emu_pkg::*;

    csr_addr_t  wr_addr_q;
    csr_data_t  wr_data_q;
    logic       aw_held;
    logic       w_held;
    logic       strb_err;
    logic       b_pend;
    axi_resp_t  bresp_q;
    logic       write_both;

    csr_addr_t  rd_addr_q;
    csr_data_t  rdata_q;
    logic       ar_held;
    logic       r_pend;

    // Both halves of the write are present
    assign write_both = aw_held && w_held;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            b_pend  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_held <= 1'b1;
            end
            if (wvalid && wready) begin
                w_held <= 1'b1;
            end
            if (write_both) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                b_pend  <= 1'b1;
            end
            if (bvalid && bready) begin
                b_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            wr_addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            wr_data_q <= wdata;
            strb_err  <= wstrb != '1;
        end
        // Response is frozen here so a new W beat cannot disturb it
        if (write_both) begin
            bresp_q <= strb_err ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
        end
    end

    assign awready = !aw_held && !b_pend;
    assign wready  = !w_held;
    assign bvalid  = b_pend;
    assign bresp   = bresp_q;

    assign regs.wr_en   = write_both && !strb_err;
    assign regs.wr_addr = wr_addr_q;
    assign regs.wr_data = wr_data_q;

    // Read channel
    always_ff @(posedge clk) begin
        if (rst) begin
            ar_held <= 1'b0;
            r_pend  <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                ar_held <= 1'b1;
            end
            if (ar_held && !r_pend) begin
                r_pend <= 1'b1;
            end
            if (rvalid && rready) begin
                ar_held <= 1'b0;
                r_pend  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rd_addr_q <= araddr;
        end
        // Sample the lookup one edge after the address is taken
        if (ar_held && !r_pend) begin
            rdata_q <= regs.rd_data;
        end
    end

    assign arready      = !ar_held;
    assign rvalid       = r_pend;
    assign rdata        = rdata_q;
    assign rresp        = `AXI_RESP_OKAY;
    assign regs.rd_addr = rd_addr_q;

    // Responses hold until the master takes them
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata));
    a_wr_en_pulse: assert property (@(posedge clk) disable iff (rst)
        regs.wr_en |=> !regs.wr_en);

endmodule

//--- verilog/emu_reg_if.sv
`timescale 1ns/1ps

interface emu_reg_if;
    import emu_pkg::*;

    // Write strobe valid for one cycle
    logic       wr_en;
    csr_addr_t  wr_addr;
    csr_data_t  wr_data;

    // rd_data follows rd_addr combinationally
    csr_addr_t  rd_addr;
    csr_data_t  rd_data;

    modport bus (
        output wr_en,
        output wr_addr,
        output wr_data,
        output rd_addr,
        input  rd_data
    );

    modport regs (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

//--- verilog/emu_pkg.sv
`include "emu_defines.svh"

package emu_pkg;

    // CSR bus words
    typedef logic [`EMU_CSR_ADDR_W-1:0]     csr_addr_t;
    typedef logic [`EMU_CSR_DATA_W-1:0]     csr_data_t;
    typedef logic [`EMU_CSR_DATA_W/8-1:0]   csr_strb_t;
    typedef logic [1:0]                     axi_resp_t;

    // Emulated design side
    typedef logic [`EMU_TRIG_W-1:0]         trig_vec_t;
    typedef logic [`EMU_CYCLE_W-1:0]        cycle_t;

endpackage

//--- verilog/emu_defines.svh
`ifndef EMU_DEFINES_SVH
`define EMU_DEFINES_SVH

// Bus and counter widths
`define EMU_CSR_ADDR_W      12
`define EMU_CSR_DATA_W      32
`define EMU_TRIG_W          32
`define EMU_CYCLE_W         64

// Register byte addresses
`define EMU_STAT            12'h000
`define EMU_TRIG_STAT       12'h004
`define EMU_CYCLE_LO        12'h008
`define EMU_CYCLE_HI        12'h00C
`define EMU_STEP            12'h010

// Status register bit positions
`define EMU_STAT_PAUSE      0
`define EMU_STAT_DUT_RST    1
`define EMU_STAT_STEP_TRIG  31

// AXI response codes
`define AXI_RESP_OKAY       2'd0
`define AXI_RESP_SLVERR     2'd2

`endif
